//--- design/oramPkg.sv
// Shared widths, types and constants of the ORAM frontend
// Referenced by scoped name from every RTL block and the testbench

`default_nettype none

package oramPkg;

    // ====================
    // Widths
    // ====================
    // 256 program blocks
    localparam int AddrWidth = 8;
    // 64 leaves, one of them reserved
    localparam int LeafWidth = 6;
    localparam int DataWidth = 32;

    typedef logic [AddrWidth-1:0] addrT;
    typedef logic [LeafWidth-1:0] leafT;
    typedef logic [DataWidth-1:0] dataT;

    // All ones marks a block outside the tree
    // As old leaf it means unmapped, as new leaf it means remove
    localparam leafT DummyLeaf = '1;

    // ====================
    // Commands
    // ====================
    // Same encoding on program side and backend side
    typedef enum logic [1:0] {
        CmdWrite   = 2'd0,
        CmdAppend  = 2'd1,
        CmdRead    = 2'd2,
        CmdReadRmv = 2'd3
    } oramCmdT;

    // One backend request, 22 bits
    typedef struct packed {
        oramCmdT cmd;
        addrT    addr;
        leafT    oldLeaf;
        leafT    newLeaf;
    } backendReqT;

endpackage

`default_nettype wire

//--- design/posMap.sv
// Flat on-chip position map with one leaf per program block
// Lookup returns the stored leaf and a valid bit one cycle after the strobe
// Also supplies fresh random leaves from an LFSR for remapping

`timescale 1ns/1ns
`default_nettype none

module posMap #(
    // Must be nonzero and not all ones
    parameter oramPkg::leafT LeafSeed = 6'd1
) (
    input  wire            Clock,
    input  wire            rstN,
    input  logic           lookupEn,
    input  oramPkg::addrT  lookupAddr,
    output oramPkg::leafT  lookupLeaf,
    output logic           lookupValid,
    input  logic           updateEn,
    input  oramPkg::addrT  updateAddr,
    input  oramPkg::leafT  updateLeaf,
    input  logic           updateSet,
    output oramPkg::leafT  freshLeaf,
    input  logic           freshTake
);

    localparam int NumBlocks = 1 << oramPkg::AddrWidth;
    // Toggle mask for x^6 + x^5 + 1, maximal length over 6 bits
    localparam oramPkg::leafT LfsrTaps = 6'b110000;

    oramPkg::leafT leafRam [NumBlocks];
    logic [NumBlocks-1:0] validBits;

    oramPkg::leafT lfsr;
    oramPkg::leafT lfsrStep;
    oramPkg::leafT lfsrNext;

    // ====================
    // Leaf storage
    // ====================
    // Contents only matter once the valid bit is set
    always_ff @(posedge Clock) begin
        if (updateEn && updateSet) begin
            leafRam[updateAddr] <= updateLeaf;
        end
        if (lookupEn) begin
            lookupLeaf <= leafRam[lookupAddr];
        end
    end

    // Valid bits, every block unmapped after reset
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            validBits   <= '0;
            lookupValid <= 1'b0;
        end else begin
            if (updateEn) begin
                // Clear on remove, set on remap
                validBits[updateAddr] <= updateSet;
            end
            if (lookupEn) begin
                lookupValid <= validBits[lookupAddr];
            end
        end
    end

    // ====================
    // Fresh leaf source
    // ====================
    function automatic oramPkg::leafT stepLfsr(input oramPkg::leafT cur);
        stepLfsr = (cur >> 1) ^ (cur[0] ? LfsrTaps : '0);
    endfunction

    // A second step hops over the reserved leaf
    always_comb begin
        lfsrStep = stepLfsr(lfsr);
        if (lfsrStep == oramPkg::DummyLeaf) begin
            lfsrNext = stepLfsr(lfsrStep);
        end else begin
            lfsrNext = lfsrStep;
        end
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            lfsr <= LeafSeed;
        end else if (freshTake) begin
            lfsr <= lfsrNext;
        end
    end

    assign freshLeaf = lfsr;

endmodule

`default_nettype wire

//--- design/syncQueue.sv
// Single-clock FIFO with ready/valid on both sides
// A pushed entry shows up at the pop side on the following cycle

`timescale 1ns/1ns
`default_nettype none

module syncQueue #(
    parameter int  Depth  = 4,
    parameter type entryT = logic
) (
    input  wire    Clock,
    input  wire    rstN,
    input  logic   pushValid,
    output logic   pushReady,
    input  entryT  pushData,
    output logic   popValid,
    input  logic   popReady,
    output entryT  popData
);

    localparam int PtrWidth   = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CountWidth = $clog2(Depth + 1);

    entryT mem [Depth];

    logic [PtrWidth-1:0]   wrPtr;
    logic [PtrWidth-1:0]   rdPtr;
    logic [CountWidth-1:0] count;

    logic doPush;
    logic doPop;

    assign pushReady = (count != CountWidth'(Depth));
    assign popValid  = (count != '0);
    assign popData   = mem[rdPtr];

    assign doPush = pushValid && pushReady;
    assign doPop  = popValid && popReady;

    // Storage
    always_ff @(posedge Clock) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    // Pointers wrap at Depth, which need not be a power of two
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            // Occupancy holds when both happen together
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/returnPath.sv
// Carries backend read responses back to the program
// Counts outstanding reads and refuses responses nobody asked for

`timescale 1ns/1ns
`default_nettype none

module returnPath #(
    parameter int MaxPending = 64
) (
    input  wire            Clock,
    input  wire            rstN,
    // Request leaving toward the backend
    input  logic           reqFire,
    input  logic           reqIsRead,
    // Backend response channel
    input  logic           LoadDataValid,
    output logic           LoadDataReady,
    input  oramPkg::dataT  LoadData,
    // Program return channel
    output logic           ReturnDataValid,
    input  logic           ReturnDataReady,
    output oramPkg::dataT  ReturnData
);

    localparam int PendWidth = $clog2(MaxPending + 1);

    logic [PendWidth-1:0] pending;
    logic                 outValid;
    oramPkg::dataT        outData;

    logic readIssued;
    logic loadFire;

    // ====================
    // Outstanding reads
    // ====================
    assign readIssued = reqFire && reqIsRead;

    // Take a beat only if a read is owed and the register can move
    assign LoadDataReady = (pending != '0) && (!outValid || ReturnDataReady);
    assign loadFire      = LoadDataValid && LoadDataReady;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pending <= '0;
        end else if (readIssued && !loadFire) begin
            pending <= pending + 1'b1;
        end else if (loadFire && !readIssued) begin
            pending <= pending - 1'b1;
        end
    end

    // ====================
    // Output register
    // ====================
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (loadFire) begin
            outValid <= 1'b1;
        end else if (ReturnDataReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge Clock) begin
        if (loadFire) begin
            outData <= LoadData;
        end
    end

    assign ReturnDataValid = outValid;
    assign ReturnData      = outData;

endmodule

`default_nettype wire

//--- design/reqIssuer.sv
// Turns program commands into backend requests
// Looks up the current leaf, remaps the block to a fresh leaf
// and pushes one backendReqT per command toward the request queue

`timescale 1ns/1ns
`default_nettype none

module reqIssuer #(
    parameter oramPkg::leafT LeafSeed = 6'd1
) (
    input  wire                  Clock,
    input  wire                  rstN,
    // Program command channel
    input  logic                 CmdInValid,
    output logic                 CmdInReady,
    input  oramPkg::oramCmdT     CmdIn,
    input  oramPkg::addrT        ProgAddrIn,
    // Push side of the request queue
    output logic                 reqValid,
    input  logic                 reqReady,
    output oramPkg::backendReqT  req
);

    typedef enum logic {
        Idle,
        Issue
    } stateT;

    stateT state;

    // Captured command, held until the push goes through
    oramPkg::oramCmdT cmdReg;
    oramPkg::addrT    addrReg;

    logic cmdAccept;
    logic pushDone;
    logic isRemove;

    // Position map handshake
    oramPkg::leafT lookupLeaf;
    logic          lookupValid;
    oramPkg::leafT freshLeaf;

    // ====================
    // Command intake
    // ====================
    // Ready drops in Issue, so one command every two cycles at best
    assign CmdInReady = (state == Idle);
    assign cmdAccept  = CmdInValid && CmdInReady;

    always_ff @(posedge Clock) begin
        if (cmdAccept) begin
            cmdReg  <= CmdIn;
            addrReg <= ProgAddrIn;
        end
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            state <= Idle;
        end else begin
            case (state)
                Idle: begin
                    if (cmdAccept) begin
                        state <= Issue;
                    end
                end
                Issue: begin
                    // Stay here while the request queue is full
                    if (pushDone) begin
                        state <= Idle;
                    end
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    // ====================
    // Request forming
    // ====================
    assign isRemove = (cmdReg == oramPkg::CmdReadRmv);
    assign reqValid = (state == Issue);
    assign pushDone = reqValid && reqReady;

    always_comb begin
        req.cmd  = cmdReg;
        req.addr = addrReg;
        // Unmapped blocks and appends are not in the tree yet
        if (!lookupValid || cmdReg == oramPkg::CmdAppend) begin
            req.oldLeaf = oramPkg::DummyLeaf;
        end else begin
            req.oldLeaf = lookupLeaf;
        end
        // A removed block leaves the tree
        req.newLeaf = isRemove ? oramPkg::DummyLeaf : freshLeaf;
    end

    // Lookup is strobed straight from the accepting edge
    // Remap is written back on the push edge, before the next lookup
    posMap #(
        .LeafSeed    (LeafSeed)
    ) posMapInst (
        .Clock       (Clock),
        .rstN        (rstN),
        .lookupEn    (cmdAccept),
        .lookupAddr  (ProgAddrIn),
        .lookupLeaf  (lookupLeaf),
        .lookupValid (lookupValid),
        .updateEn    (pushDone),
        .updateAddr  (addrReg),
        .updateLeaf  (freshLeaf),
        .updateSet   (!isRemove),
        .freshLeaf   (freshLeaf),
        // Only advance when the leaf was actually handed out
        .freshTake   (pushDone && !isRemove)
    );

endmodule

`default_nettype wire

//--- design/frontend.sv
// Top of the Path ORAM frontend
// Program commands go through the issuer and request queue to the backend,
// write data through the store queue, read data back through the return path

`timescale 1ns/1ns
`default_nettype none

module frontend #(
    parameter int            ReqDepth   = 4,
    parameter int            StoreDepth = 4,
    parameter oramPkg::leafT LeafSeed   = 6'd1
) (
    input  wire                  Clock,
    input  wire                  rstN,
    // ====================
    // Program side
    // ====================
    input  logic                 CmdInValid,
    output logic                 CmdInReady,
    input  oramPkg::oramCmdT     CmdIn,
    input  oramPkg::addrT        ProgAddrIn,
    input  logic                 DataInValid,
    output logic                 DataInReady,
    input  oramPkg::dataT        DataIn,
    output logic                 ReturnDataValid,
    input  logic                 ReturnDataReady,
    output oramPkg::dataT        ReturnData,
    // ====================
    // Backend side
    // ====================
    output logic                 CmdOutValid,
    input  logic                 CmdOutReady,
    output oramPkg::backendReqT  CmdOut,
    output logic                 StoreDataValid,
    input  logic                 StoreDataReady,
    output oramPkg::dataT        StoreData,
    input  logic                 LoadDataValid,
    output logic                 LoadDataReady,
    input  oramPkg::dataT        LoadData
);

    // Reads the backend may have in flight at once
    localparam int MaxPending = 64;

    logic                reqValid;
    logic                reqReady;
    oramPkg::backendReqT req;

    logic reqFire;
    logic reqIsRead;

    // Lookup, remap and request build
    reqIssuer #(
        .LeafSeed   (LeafSeed)
    ) issuer (
        .Clock      (Clock),
        .rstN       (rstN),
        .CmdInValid (CmdInValid),
        .CmdInReady (CmdInReady),
        .CmdIn      (CmdIn),
        .ProgAddrIn (ProgAddrIn),
        .reqValid   (reqValid),
        .reqReady   (reqReady),
        .req        (req)
    );

    // Requests wait here for the backend
    syncQueue #(
        .Depth     (ReqDepth),
        .entryT    (oramPkg::backendReqT)
    ) reqQueue (
        .Clock     (Clock),
        .rstN      (rstN),
        .pushValid (reqValid),
        .pushReady (reqReady),
        .pushData  (req),
        .popValid  (CmdOutValid),
        .popReady  (CmdOutReady),
        .popData   (CmdOut)
    );

    // Write data runs beside the commands, paired in order by the backend
    syncQueue #(
        .Depth     (StoreDepth),
        .entryT    (oramPkg::dataT)
    ) storeQueue (
        .Clock     (Clock),
        .rstN      (rstN),
        .pushValid (DataInValid),
        .pushReady (DataInReady),
        .pushData  (DataIn),
        .popValid  (StoreDataValid),
        .popReady  (StoreDataReady),
        .popData   (StoreData)
    );

    // Both read kinds expect one response beat
    assign reqFire   = CmdOutValid && CmdOutReady;
    assign reqIsRead = (CmdOut.cmd == oramPkg::CmdRead) ||
                       (CmdOut.cmd == oramPkg::CmdReadRmv);

    returnPath #(
        .MaxPending      (MaxPending)
    ) retPath (
        .Clock           (Clock),
        .rstN            (rstN),
        .reqFire         (reqFire),
        .reqIsRead       (reqIsRead),
        .LoadDataValid   (LoadDataValid),
        .LoadDataReady   (LoadDataReady),
        .LoadData        (LoadData),
        .ReturnDataValid (ReturnDataValid),
        .ReturnDataReady (ReturnDataReady),
        .ReturnData      (ReturnData)
    );

endmodule

`default_nettype wire

//--- dv/frontendTb.sv
// Directed testbench for the ORAM frontend
// Plays the backend, keeps a leaf map and data memory per block,
// and checks leaf chains, store order and returned data

`timescale 1ns/1ns
`default_nettype none

module frontendTb;

    localparam int TimeoutCycles = 400;
    localparam int RandomOps     = 24;
    localparam int NumBlocks     = 1 << oramPkg::AddrWidth;

    logic Clock;
    logic rstN;

    // Program side
    logic                 CmdInValid;
    logic                 CmdInReady;
    oramPkg::oramCmdT     CmdIn;
    oramPkg::addrT        ProgAddrIn;
    logic                 DataInValid;
    logic                 DataInReady;
    oramPkg::dataT        DataIn;
    logic                 ReturnDataValid;
    logic                 ReturnDataReady;
    oramPkg::dataT        ReturnData;

    // Backend side
    logic                 CmdOutValid;
    logic                 CmdOutReady;
    oramPkg::backendReqT  CmdOut;
    logic                 StoreDataValid;
    logic                 StoreDataReady;
    oramPkg::dataT        StoreData;
    logic                 LoadDataValid = 1'b0;
    logic                 LoadDataReady;
    oramPkg::dataT        LoadData = '0;

    int    errCount;
    int    tmoCount;
    int    retCount;
    string testName;

    // Commands accepted by the DUT and requests seen by the backend
    int    cmdSent;
    int    cmdSeen;

    // Backend model state
    oramPkg::dataT       refMem   [NumBlocks];
    oramPkg::leafT       refLeaf  [NumBlocks];
    bit                  refValid [NumBlocks];
    oramPkg::addrT       wrAddrQ [$];
    oramPkg::dataT       beatQ [$];
    oramPkg::dataT       loadQ [$];
    oramPkg::backendReqT lastReq;

    // Program side model
    oramPkg::dataT progMem   [NumBlocks];
    bit            progValid [NumBlocks];
    oramPkg::dataT expQ [$];

    logic [15:0] lfsrState;

    frontend #(
        .ReqDepth   (4),
        .StoreDepth (4),
        .LeafSeed   (6'd1)
    ) UUT (
        .Clock           (Clock),
        .rstN            (rstN),
        .CmdInValid      (CmdInValid),
        .CmdInReady      (CmdInReady),
        .CmdIn           (CmdIn),
        .ProgAddrIn      (ProgAddrIn),
        .DataInValid     (DataInValid),
        .DataInReady     (DataInReady),
        .DataIn          (DataIn),
        .ReturnDataValid (ReturnDataValid),
        .ReturnDataReady (ReturnDataReady),
        .ReturnData      (ReturnData),
        .CmdOutValid     (CmdOutValid),
        .CmdOutReady     (CmdOutReady),
        .CmdOut          (CmdOut),
        .StoreDataValid  (StoreDataValid),
        .StoreDataReady  (StoreDataReady),
        .StoreData       (StoreData),
        .LoadDataValid   (LoadDataValid),
        .LoadDataReady   (LoadDataReady),
        .LoadData        (LoadData)
    );

    initial begin
        Clock = 1'b0;
    end

    always #10 Clock = ~Clock;

    // ====================
    // Random source
    // ====================
    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic stepBit();
        logic fb;
        fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
        lfsrState = {lfsrState[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], stepBit()};
        end
        return val;
    endfunction

    // ====================
    // Compare tasks
    // ====================
    task automatic checkLeaf(input string what, input oramPkg::leafT exp,
                             input oramPkg::leafT act);
        if (exp !== act) begin
            errCount++;
            $display("ERR %s %s: expected %0h, actual %0h", testName, what, exp, act);
        end
    endtask

    task automatic checkData(input string what, input oramPkg::dataT exp,
                             input oramPkg::dataT act);
        if (exp !== act) begin
            errCount++;
            $display("ERR %s %s: expected %h, actual %h", testName, what, exp, act);
        end
    endtask

    task automatic checkCmd(input string what, input oramPkg::oramCmdT exp,
                            input oramPkg::oramCmdT act);
        if (exp !== act) begin
            errCount++;
            $display("ERR %s %s: expected %0d, actual %0d", testName, what, exp, act);
        end
    endtask

    task automatic checkFlag(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            errCount++;
            $display("ERR %s %s: expected %b, actual %b", testName, what, exp, act);
        end
    endtask

    task automatic checkCycles(input string what, input int exp, input int act);
        if (exp != act) begin
            errCount++;
            $display("ERR %s %s: expected %0d, actual %0d", testName, what, exp, act);
        end
    endtask

    // ====================
    // Backend model
    // ====================
    // Store beats pair in order with Write and Append requests
    function automatic void pairStores();
        while (wrAddrQ.size() != 0 && beatQ.size() != 0) begin
            refMem[wrAddrQ.pop_front()] = beatQ.pop_front();
        end
    endfunction

    always @(posedge Clock) begin
        oramPkg::backendReqT r;
        oramPkg::leafT       expOld;
        if (rstN) begin
            if (StoreDataValid && StoreDataReady) begin
                beatQ.push_back(StoreData);
                pairStores();
            end
            if (CmdOutValid && CmdOutReady) begin
                r = CmdOut;
                lastReq = r;
                cmdSeen++;
                // Leaf map check before the remap
                if (r.cmd == oramPkg::CmdAppend || !refValid[r.addr]) begin
                    expOld = oramPkg::DummyLeaf;
                end else begin
                    expOld = refLeaf[r.addr];
                end
                checkLeaf("oldLeaf", expOld, r.oldLeaf);
                if (r.cmd == oramPkg::CmdReadRmv) begin
                    checkLeaf("newLeaf", oramPkg::DummyLeaf, r.newLeaf);
                    refValid[r.addr] = 1'b0;
                end else begin
                    if (r.newLeaf == oramPkg::DummyLeaf) begin
                        errCount++;
                        $display("%s: block %0h was remapped to the reserved leaf",
                                 testName, r.addr);
                    end
                    refValid[r.addr] = 1'b1;
                    refLeaf[r.addr]  = r.newLeaf;
                end
                if (r.cmd == oramPkg::CmdWrite || r.cmd == oramPkg::CmdAppend) begin
                    wrAddrQ.push_back(r.addr);
                    pairStores();
                end else begin
                    loadQ.push_back(refMem[r.addr]);
                    // Removed blocks read back as zero
                    if (r.cmd == oramPkg::CmdReadRmv) begin
                        refMem[r.addr] = '0;
                    end
                end
            end
            if (LoadDataValid && LoadDataReady) begin
                void'(loadQ.pop_front());
            end
            LoadDataValid <= (loadQ.size() != 0);
            LoadData      <= (loadQ.size() != 0) ? loadQ[0] : '0;
        end
    end

    // Returned beats against the program-side expectation
    always @(posedge Clock) begin
        if (rstN && ReturnDataValid && ReturnDataReady) begin
            retCount++;
            if (expQ.size() == 0) begin
                errCount++;
                $display("%s: return beat %h arrived with no read outstanding",
                         testName, ReturnData);
            end else begin
                checkData("ReturnData", expQ.pop_front(), ReturnData);
            end
        end
    end

    // ====================
    // Program side driving
    // ====================
    task automatic sendCmd(input oramPkg::oramCmdT cmd, input oramPkg::addrT addr);
        int n;
        @(posedge Clock);
        CmdInValid <= 1'b1;
        CmdIn      <= cmd;
        ProgAddrIn <= addr;
        n = 0;
        while (1) begin
            @(posedge Clock);
            if (CmdInReady) begin
                cmdSent++;
                break;
            end
            n++;
            if (n > TimeoutCycles) begin
                tmoCount++;
                $display("%s: command was never accepted", testName);
                break;
            end
        end
        CmdInValid <= 1'b0;
    endtask

    task automatic sendData(input oramPkg::dataT data);
        int n;
        @(posedge Clock);
        DataInValid <= 1'b1;
        DataIn      <= data;
        n = 0;
        while (1) begin
            @(posedge Clock);
            if (DataInReady) begin
                break;
            end
            n++;
            if (n > TimeoutCycles) begin
                tmoCount++;
                $display("%s: write data was never accepted", testName);
                break;
            end
        end
        DataInValid <= 1'b0;
    endtask

    // One program operation, with the expected data recorded up front
    task automatic doOp(input oramPkg::oramCmdT cmd, input oramPkg::addrT addr,
                        input oramPkg::dataT data);
        if (cmd == oramPkg::CmdWrite || cmd == oramPkg::CmdAppend) begin
            sendData(data);
            progMem[addr] = data;
            progValid[addr] = 1'b1;
        end else begin
            expQ.push_back(progMem[addr]);
            if (cmd == oramPkg::CmdReadRmv) begin
                progMem[addr] = '0;
                progValid[addr] = 1'b0;
            end else begin
                progValid[addr] = 1'b1;
            end
        end
        sendCmd(cmd, addr);
    endtask

    // Everything issued has reached the backend, been answered and drained
    task automatic waitIdle();
        int n;
        n = 0;
        while (expQ.size() != 0 || loadQ.size() != 0 || CmdOutValid ||
               StoreDataValid || !CmdInReady || cmdSent != cmdSeen ||
               wrAddrQ.size() != 0) begin
            @(posedge Clock);
            n++;
            if (n > TimeoutCycles) begin
                tmoCount++;
                $display("%s: traffic did not drain", testName);
                break;
            end
        end
        @(posedge Clock);
    endtask

    // ====================
    // Directed tests
    // ====================
    task automatic testReset();
        testName = "reset";
        checkFlag("CmdOutValid", 1'b0, CmdOutValid);
        checkFlag("StoreDataValid", 1'b0, StoreDataValid);
        checkFlag("ReturnDataValid", 1'b0, ReturnDataValid);
        checkFlag("LoadDataReady", 1'b0, LoadDataReady);
        checkFlag("CmdInReady", 1'b1, CmdInReady);
        checkFlag("DataInReady", 1'b1, DataInReady);
    endtask

    task automatic testAppendRead();
        oramPkg::leafT appendLeaf;
        int n;
        testName = "appendRead";
        sendData(32'hA5A5_0001);
        progMem[8'h10] = 32'hA5A5_0001;
        progValid[8'h10] = 1'b1;
        sendCmd(oramPkg::CmdAppend, 8'h10);
        // Accepted on the last edge, request expected two edges later
        n = 0;
        while (!CmdOutValid && n <= TimeoutCycles) begin
            @(posedge Clock);
            n++;
        end
        if (!CmdOutValid) begin
            tmoCount++;
            $display("%s: request never reached the backend", testName);
        end
        checkCycles("request latency", 2, n);
        waitIdle();
        checkCmd("cmd", oramPkg::CmdAppend, lastReq.cmd);
        checkLeaf("append oldLeaf", oramPkg::DummyLeaf, lastReq.oldLeaf);
        appendLeaf = lastReq.newLeaf;
        doOp(oramPkg::CmdRead, 8'h10, '0);
        waitIdle();
        checkCmd("cmd", oramPkg::CmdRead, lastReq.cmd);
        checkLeaf("read oldLeaf", appendLeaf, lastReq.oldLeaf);
    endtask

    task automatic testLeafChain();
        oramPkg::leafT prevNew;
        testName = "leafChain";
        prevNew = oramPkg::DummyLeaf;
        for (int i = 0; i < 6; i++) begin
            if (i % 2 == 0) begin
                doOp(oramPkg::CmdWrite, 8'h20, 32'hC0DE_0000 + i);
            end else begin
                doOp(oramPkg::CmdRead, 8'h20, '0);
            end
            waitIdle();
            checkLeaf("chained oldLeaf", prevNew, lastReq.oldLeaf);
            prevNew = lastReq.newLeaf;
        end
    endtask

    task automatic testReadRemove();
        testName = "readRemove";
        doOp(oramPkg::CmdWrite, 8'h30, 32'h1234_5678);
        doOp(oramPkg::CmdReadRmv, 8'h30, '0);
        waitIdle();
        checkCmd("cmd", oramPkg::CmdReadRmv, lastReq.cmd);
        checkLeaf("remove newLeaf", oramPkg::DummyLeaf, lastReq.newLeaf);
        doOp(oramPkg::CmdRead, 8'h30, '0);
        waitIdle();
        checkLeaf("after remove oldLeaf", oramPkg::DummyLeaf, lastReq.oldLeaf);
    endtask

    task automatic testBackPressure();
        int startRet;
        int n;
        testName = "backPressure";
        startRet = retCount;
        @(posedge Clock);
        CmdOutReady     <= 1'b0;
        StoreDataReady  <= 1'b0;
        ReturnDataReady <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            doOp(oramPkg::CmdWrite, oramPkg::addrT'(8'h40 + i), 32'hBEEF_0000 + i);
        end
        // Queue holds four, the issuer keeps the fifth
        doOp(oramPkg::CmdRead, 8'h40, '0);
        repeat (3) @(posedge Clock);
        checkFlag("CmdInReady stalled", 1'b0, CmdInReady);
        checkFlag("DataInReady stalled", 1'b0, DataInReady);
        CmdOutReady    <= 1'b1;
        StoreDataReady <= 1'b1;
        for (int i = 1; i < 4; i++) begin
            doOp(oramPkg::CmdRead, oramPkg::addrT'(8'h40 + i), '0);
        end
        // Output register full, so the response must wait
        n = 0;
        while (!(LoadDataValid && !LoadDataReady && ReturnDataValid)) begin
            @(posedge Clock);
            n++;
            if (n > TimeoutCycles) begin
                tmoCount++;
                $display("%s: response channel never stalled", testName);
                break;
            end
        end
        repeat (2) @(posedge Clock);
        checkFlag("LoadDataReady stalled", 1'b0, LoadDataReady);
        ReturnDataReady <= 1'b1;
        waitIdle();
        checkCycles("returned beats", 4, retCount - startRet);
    endtask

    task automatic testRandom();
        logic [1:0]       pick;
        logic [2:0]       low;
        oramPkg::oramCmdT cmd;
        oramPkg::addrT    addr;
        testName = "random";
        for (int i = 0; i < RandomOps; i++) begin
            pick = 2'(randBits(2));
            low  = 3'(randBits(3));
            cmd  = oramPkg::oramCmdT'(pick);
            addr = {5'b01010, low};
            // Append only installs a block that is not mapped
            if (cmd == oramPkg::CmdAppend && progValid[addr]) begin
                cmd = oramPkg::CmdWrite;
            end
            doOp(cmd, addr, randBits(32));
        end
        waitIdle();
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        errCount  = 0;
        tmoCount  = 0;
        retCount  = 0;
        cmdSent   = 0;
        cmdSeen   = 0;
        testName  = "init";
        lfsrState = 16'd2172;
        for (int i = 0; i < NumBlocks; i++) begin
            refMem[i]    = '0;
            refLeaf[i]   = oramPkg::DummyLeaf;
            refValid[i]  = 1'b0;
            progMem[i]   = '0;
            progValid[i] = 1'b0;
        end
        rstN            <= 1'b0;
        CmdInValid      <= 1'b0;
        CmdIn           <= oramPkg::CmdRead;
        ProgAddrIn      <= '0;
        DataInValid     <= 1'b0;
        DataIn          <= '0;
        ReturnDataReady <= 1'b1;
        CmdOutReady     <= 1'b1;
        StoreDataReady  <= 1'b1;
        repeat (2) @(posedge Clock);
        rstN <= 1'b1;
        @(posedge Clock);

        testReset();
        testAppendRead();
        testLeafChain();
        testReadRemove();
        testBackPressure();
        testRandom();

        $display("Value errors: %0d, timeouts: %0d", errCount, tmoCount);
        if (errCount == 0 && tmoCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Hard limit on the whole run
    initial begin
        #400000;
        $display("Simulation ran past its time limit");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
design/oramPkg.sv
design/posMap.sv
design/syncQueue.sv
design/returnPath.sv
design/reqIssuer.sv
design/frontend.sv
dv/frontendTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the ORAM frontend testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module frontendTb -f sim.f -o simv

out=$(./obj_dir/simv)
echo "$out"
grep -q "All tests passed!" <<< "$out"
